// ==== src.f ====
+incdir+bench
verilog/send_pkg.sv
verilog/send_timer.sv
verilog/send_channel.sv
verilog/status_leds.sv
verilog/send_sched_top.sv
bench/tb_send_sched.sv

// ==== Makefile ====
# Verilator build and run of the send scheduler testbench

TOP := tb_send_sched

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only -Wall --top-module send_sched_top \
		verilog/send_pkg.sv \
		verilog/send_timer.sv \
		verilog/send_channel.sv \
		verilog/status_leds.sv \
		verilog/send_sched_top.sv

clean:
	rm -rf obj_dir

// ==== bench/tb_model.svh ====
// testbench model: state record, xorshift generator, reference next-state function, compare tasks

typedef struct packed {
    logic                                          run;
    send_pkg::count_t                              count;
    logic                [send_pkg::NUM_PORTS-1:0] first_done;
    logic                [send_pkg::NUM_PORTS-1:0] cmd;
    send_pkg::ram_addr_t [send_pkg::NUM_PORTS-1:0] addr;
    logic                [15:0]                    blink_cnt;
    logic                                          blink;
    logic                                          link;
    logic [send_pkg::NUM_PORTS-1:0][7:0]           hold;   // activity stretch per port
} model_t;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// one clock of the scheduler, taken straight from the timing rules
function automatic model_t next_state(input model_t s, input logic mac, input logic rx,
                                      input logic [send_pkg::NUM_PORTS-1:0] ds);
    model_t n;
    logic   sched;
    n      = s;
    n.run  = mac & rx;
    n.link = s.run;
    if (s.blink_cnt == 16'(send_pkg::BLINK_HALF - 1))
    begin
        n.blink_cnt = 16'd0;
        n.blink     = ~s.blink;
    end
    else
        n.blink_cnt = s.blink_cnt + 16'd1;
    if (s.run)
    begin
        if (s.count == send_pkg::count_t'(send_pkg::CYCLE_LEN - 1))
            n.count = '0;
        else
            n.count = s.count + 1;
    end
    for (int p = 0; p < send_pkg::NUM_PORTS; p++)
    begin
        if (s.cmd[p])
            n.hold[p] = 8'(send_pkg::ACT_HOLD);
        else if (s.hold[p] != 8'd0)
            n.hold[p] = s.hold[p] - 8'd1;
        sched = !send_pkg::ECHO_MODE[p] || !s.first_done[p];
        if (s.run && sched)
        begin
            if (s.count == send_pkg::SEND_AT[p])
            begin
                n.cmd[p]  = 1'b1;
                n.addr[p] = send_pkg::START_ADDR[p];
            end
            else if (s.count == send_pkg::SEND_AT[p] + send_pkg::PULSE_LEN)
            begin
                n.cmd[p]        = 1'b0;
                n.first_done[p] = send_pkg::ECHO_MODE[p];
            end
        end
        else if (s.run)
        begin
            if (ds[p] && !s.cmd[p])
            begin
                n.cmd[p]  = 1'b1;   // echo of data saved
                n.addr[p] = send_pkg::START_ADDR[p];
            end
            else if (!ds[p])
                n.cmd[p] = 1'b0;
        end
    end
    return n;
endfunction

task automatic check_cmd(input logic got, input logic exp, input string what);
    if (got !== exp)
        abort_run($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

task automatic check_addr(input send_pkg::ram_addr_t got, input send_pkg::ram_addr_t exp,
                          input string what);
    if (got !== exp)
        abort_run($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
endtask

task automatic check_led(input logic got, input logic exp, input string what);
    if (got !== exp)
        abort_run($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

// ==== bench/tb_send_sched.sv ====
// send scheduler testbench with clock, reset, stimulus, model stepping and comparison
`timescale 1ns/1ps

module tb_send_sched;

    logic                                          clk_50_pll = 1'b0;
    logic                                          main_reset;
    logic                                          mac_inited;
    logic                                          rx_ready;
    logic                [send_pkg::NUM_PORTS-1:0] data_saved;
    logic                [send_pkg::NUM_PORTS-1:0] cmd_send;
    send_pkg::ram_addr_t [send_pkg::NUM_PORTS-1:0] start_ram_addr;
    logic                                          blink_led;
    logic                                          link_led;
    logic                [send_pkg::NUM_PORTS-1:0] act_led;

    logic [31:0] rnd      = 32'd37345;
    int          p1_rises = 0;       // rising edges of port 1 command
    logic        p1_prev  = 1'b0;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    `include "tb_model.svh"

    model_t m = '0;

    send_sched_top send_sched_top_i
    (
        .clk_50_pll     (clk_50_pll),
        .main_reset     (main_reset),
        .mac_inited     (mac_inited),
        .rx_ready       (rx_ready),
        .data_saved     (data_saved),
        .cmd_send       (cmd_send),
        .start_ram_addr (start_ram_addr),
        .blink_led      (blink_led),
        .link_led       (link_led),
        .act_led        (act_led)
    );

    always #10 clk_50_pll = ~clk_50_pll;

    // ------------------------------------------------------------------------
    // model and comparison
    // ------------------------------------------------------------------------
    always @(posedge clk_50_pll)
    begin
        if (main_reset)
            m = '0;
        else
            m = next_state(m, mac_inited, rx_ready, data_saved);
    end

    always @(negedge clk_50_pll)
    begin
        for (int p = 0; p < send_pkg::NUM_PORTS; p++)
        begin
            check_cmd(cmd_send[p], m.cmd[p], $sformatf("cmd_send[%0d]", p));
            check_addr(start_ram_addr[p], m.addr[p], $sformatf("start_ram_addr[%0d]", p));
            check_led(act_led[p], m.hold[p] != 8'd0, $sformatf("act_led[%0d]", p));
        end
        check_led(blink_led, m.blink, "blink_led");
        check_led(link_led, m.link, "link_led");
        if (cmd_send[1] && !p1_prev)
            p1_rises++;
        p1_prev = cmd_send[1];
    end

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    task automatic idle_quiet(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk_50_pll);
            check_cmd(cmd_send[0], 1'b0, "cmd_send[0] while stopped");
            check_cmd(cmd_send[1], 1'b0, "cmd_send[1] while stopped");
        end
    endtask

    task automatic wait_cmd_level(input int p, input logic level, input int limit);
        int n;
        n = 0;
        @(negedge clk_50_pll);
        while (cmd_send[p] !== level)
        begin
            if (n == limit)
                abort_run($sformatf("timed out waiting for cmd_send[%0d] to become %b", p, level));
            n++;
            @(negedge clk_50_pll);
        end
    endtask

    // called on the first cycle the command is seen high
    task automatic expect_pulse(input int p, input send_pkg::ram_addr_t addr);
        int k;
        check_addr(start_ram_addr[p], addr, $sformatf("start address of port %0d", p));
        for (k = 1; k < send_pkg::PULSE_LEN; k++)
        begin
            @(negedge clk_50_pll);
            check_cmd(cmd_send[p], 1'b1, $sformatf("cmd_send[%0d] inside pulse", p));
        end
        @(negedge clk_50_pll);
        check_cmd(cmd_send[p], 1'b0, $sformatf("cmd_send[%0d] after pulse", p));
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial
    begin
        main_reset = 1'b1;
        mac_inited = 1'b0;
        rx_ready   = 1'b0;
        data_saved = '0;
        repeat (10) @(negedge clk_50_pll);
        main_reset = 1'b0;
        for (int p = 0; p < send_pkg::NUM_PORTS; p++)
        begin
            check_addr(start_ram_addr[p], '0, "start address after reset");
            check_led(act_led[p], 1'b0, "act_led after reset");
        end

        rx_ready = 1'b1;                 // MAC still down
        idle_quiet(send_pkg::CYCLE_LEN);
        mac_inited = 1'b1;
        rx_ready   = 1'b0;
        idle_quiet(send_pkg::CYCLE_LEN);

        // periodic port 0 and the single scheduled shot of port 1
        rx_ready = 1'b1;
        wait_cmd_level(0, 1'b1, send_pkg::CYCLE_LEN + 8);
        expect_pulse(0, send_pkg::START_ADDR[0]);
        wait_cmd_level(1, 1'b1, send_pkg::CYCLE_LEN);
        expect_pulse(1, send_pkg::START_ADDR[1]);
        repeat (2)
        begin
            wait_cmd_level(0, 1'b1, send_pkg::CYCLE_LEN + 8);
            expect_pulse(0, send_pkg::START_ADDR[0]);
        end
        repeat (300) @(negedge clk_50_pll);   // past the port 1 slot again
        if (p1_rises != 1)
            abort_run($sformatf("Mismatch at %0t: port 1 fired %0d times, expected 1",
                                $time, p1_rises));

        // freeze in the middle of a port 0 pulse
        wait_cmd_level(0, 1'b1, send_pkg::CYCLE_LEN + 8);
        rx_ready = 1'b0;
        repeat (6)
        begin
            @(negedge clk_50_pll);
            check_cmd(cmd_send[0], 1'b1, "cmd_send[0] while frozen");
            check_cmd(cmd_send[1], 1'b0, "cmd_send[1] while frozen");
            data_saved = 2'b10;          // a running echo port would rise
        end
        rx_ready   = 1'b1;
        data_saved = '0;
        wait_cmd_level(0, 1'b0, 8);

        // random data saved levels with short receive drops
        for (int i = 0; i < 3 * send_pkg::CYCLE_LEN; i++)
        begin
            @(negedge clk_50_pll);
            rnd = xorshift32(rnd);
            if (rnd[2:0] == 3'd0)
                data_saved = rnd[4:3];
            rx_ready = (rnd[9:5] != 5'd0);
        end
        rx_ready   = 1'b1;
        data_saved = '0;
        repeat (2 * send_pkg::ACT_HOLD) @(negedge clk_50_pll);
        if (p1_rises < 2)
        begin
            abort_run("port 1 never echoed a data saved level");
        end
        else
        begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== verilog/send_sched_top.sv ====
// top level: send timer, generated send channels and status LED block
`timescale 1ns/1ps

module send_sched_top
(
    input  logic                                             clk_50_pll,
    input  logic                                             main_reset,

    input  logic                                             mac_inited,
    input  logic                                             rx_ready,
    input  logic                [send_pkg::NUM_PORTS-1:0]    data_saved,

    output logic                [send_pkg::NUM_PORTS-1:0]    cmd_send,
    output send_pkg::ram_addr_t [send_pkg::NUM_PORTS-1:0]    start_ram_addr,

    output logic                                             blink_led,
    output logic                                             link_led,
    output logic                [send_pkg::NUM_PORTS-1:0]    act_led
);

    logic             run;
    send_pkg::count_t count;

    // ------------------------------------------------------------------------
    // shared send timer
    // ------------------------------------------------------------------------
    send_timer send_timer_i
    (
        .clk_50_pll (clk_50_pll),
        .main_reset (main_reset),
        .mac_inited (mac_inited),
        .rx_ready   (rx_ready),
        .run        (run),
        .count      (count)
    );

    // ------------------------------------------------------------------------
    // one channel per Ethernet port
    // ------------------------------------------------------------------------
    generate
        for (genvar i = 0; i < send_pkg::NUM_PORTS; i++)
        begin : g_chan
            send_channel #(.port_index(i)) send_channel_i
            (
                .clk_50_pll (clk_50_pll),
                .main_reset (main_reset),
                .run        (run),
                .count      (count),
                .data_saved (data_saved[i]),
                .cmd_send   (cmd_send[i]),
                .start_addr (start_ram_addr[i])
            );
        end
    endgenerate

    status_leds status_leds_i
    (
        .clk_50_pll (clk_50_pll),
        .main_reset (main_reset),
        .run        (run),
        .cmd_send   (cmd_send),
        .blink_led  (blink_led),
        .link_led   (link_led),
        .act_led    (act_led)
    );

endmodule

// ==== verilog/status_leds.sv ====
// status LEDs: health blink divider, link LED and stretched per-port activity LEDs
`timescale 1ns/1ps

module status_leds
(
    input  logic                          clk_50_pll,
    input  logic                          main_reset,

    input  logic                          run,
    input  logic [send_pkg::NUM_PORTS-1:0] cmd_send,

    output logic                          blink_led,
    output logic                          link_led,
    output logic [send_pkg::NUM_PORTS-1:0] act_led
);

    logic [send_pkg::BLINK_W-1:0] blink_cnt;

    // ------------------------------------------------------------------------
    // health blink, independent of run
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            blink_cnt <= '0;
            blink_led <= 1'b0;
        end
        else if (blink_cnt == send_pkg::BLINK_LAST)
        begin
            blink_cnt <= '0;
            blink_led <= ~blink_led;
        end
        else
        begin
            blink_cnt <= blink_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
            link_led <= 1'b0;
        else
            link_led <= run;   // one cycle behind the timer
    end

    // ------------------------------------------------------------------------
    // activity stretch, one hold counter per port
    // ------------------------------------------------------------------------
    generate
        for (genvar i = 0; i < send_pkg::NUM_PORTS; i++)
        begin : g_act
            logic [send_pkg::ACT_W-1:0] hold_cnt;

            always_ff @(posedge clk_50_pll or posedge main_reset)
            begin
                if (main_reset)
                    hold_cnt <= '0;
                else if (cmd_send[i])
                    hold_cnt <= send_pkg::ACT_LOAD;   // reload while command is up
                else if (hold_cnt != '0)
                    hold_cnt <= hold_cnt - 1'b1;
            end

            assign act_led[i] = (hold_cnt != '0);

            // a command from the channel shows up on the next clock
            a_act_follows : assert property (@(posedge clk_50_pll) disable iff (main_reset)
                cmd_send[i] |=> act_led[i]);
        end
    endgenerate

endmodule

// ==== verilog/send_channel.sv ====
// send channel: scheduled command pulse, one-shot flag and data-saved echo follower
`timescale 1ns/1ps

module send_channel
#(
    parameter int port_index = 0
)
(
    input  logic                clk_50_pll,
    input  logic                main_reset,

    input  logic                run,
    input  send_pkg::count_t    count,
    input  logic                data_saved,

    output logic                cmd_send,
    output send_pkg::ram_addr_t start_addr
);

    // ------------------------------------------------------------------------
    // per-port configuration
    // ------------------------------------------------------------------------
    localparam send_pkg::count_t    slot      = send_pkg::SEND_AT[port_index];
    localparam send_pkg::count_t    pulse_end = slot + send_pkg::PULSE_LEN;
    localparam send_pkg::ram_addr_t addr      = send_pkg::START_ADDR[port_index];
    localparam bit                  echo_mode = send_pkg::ECHO_MODE[port_index];

    logic first_done;   // scheduled shot already sent
    logic sched_on;

    // periodic channels never leave the schedule
    assign sched_on = !echo_mode || !first_done;

    // ------------------------------------------------------------------------
    // command generator
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            cmd_send   <= 1'b0;
            start_addr <= '0;
            first_done <= 1'b0;
        end
        else if (run)
        begin
            if (sched_on && count == slot)
            begin
                cmd_send   <= 1'b1;
                start_addr <= addr;
            end
            else if (sched_on && count == pulse_end)
            begin
                cmd_send   <= 1'b0;
                first_done <= echo_mode;   // echo ports leave the schedule here
            end
            else if (!sched_on)
            begin
                // follow the receive side once the first shot is out
                if (data_saved && !cmd_send)
                begin
                    cmd_send   <= 1'b1;
                    start_addr <= addr;
                end
                else if (!data_saved)
                begin
                    cmd_send <= 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    // command and timer must freeze together
    a_hold_stopped : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        !run |=> $stable(cmd_send));

    generate
        if (!echo_mode)
        begin : g_periodic_chk
            // a periodic command only lives inside its own slot window
            a_in_window : assert property (@(posedge clk_50_pll) disable iff (main_reset)
                cmd_send |-> (count > slot && count <= pulse_end));
        end
    endgenerate

endmodule

// ==== verilog/send_timer.sv ====
// send timer: registered run qualifier and wrapping send period counter
`timescale 1ns/1ps

module send_timer
(
    input  logic             clk_50_pll,
    input  logic             main_reset,

    input  logic             mac_inited,
    input  logic             rx_ready,

    output logic             run,
    output send_pkg::count_t count
);

    // MAC up and receive side locked
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            run <= 1'b0;
        end
        else
        begin
            run <= mac_inited & rx_ready;
        end
    end

    // free running period counter, frozen while not running
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            count <= '0;
        end
        else if (run)
        begin
            if (count == send_pkg::CYCLE_LAST)
                count <= '0;            // end of period
            else
                count <= count + 1'b1;
        end
    end

    // channels rely on every slot value being reachable within one period
    a_count_bound : assert property (@(posedge clk_50_pll) disable iff (main_reset)
        count <= send_pkg::CYCLE_LAST);

endmodule

// ==== verilog/send_pkg.sv ====
// send scheduler sizes, shared types, timer constants, per-port tables, LED constants
package send_pkg;

    // ------------------------------------------------------------------------
    // sizes and shared types
    // ------------------------------------------------------------------------
    localparam int NUM_PORTS = 2;
    localparam int ADDR_W    = 25;   // start RAM address width
    localparam int CNT_W     = 32;   // send timer width

    typedef logic [ADDR_W-1:0] ram_addr_t;
    typedef logic [CNT_W-1:0]  count_t;

    // ------------------------------------------------------------------------
    // send timer and command shape
    // ------------------------------------------------------------------------
    // period ends ten counts past the second slot
    localparam int     CYCLE_LEN  = 522;
    localparam count_t CYCLE_LAST = count_t'(CYCLE_LEN - 1);

    localparam count_t PULSE_LEN = 3;   // scheduled command length

    // per-port schedule
    localparam count_t    SEND_AT    [NUM_PORTS] = '{32'd255, 32'd511};
    localparam ram_addr_t START_ADDR [NUM_PORTS] = '{25'd1, 25'd5};

    // 0 periodic, 1 one shot then echo of data saved
    localparam bit ECHO_MODE [NUM_PORTS] = '{1'b0, 1'b1};

    // ------------------------------------------------------------------------
    // status LEDs
    // ------------------------------------------------------------------------
    localparam int BLINK_HALF = 250;
    localparam int BLINK_W    = $clog2(BLINK_HALF);
    localparam logic [BLINK_W-1:0] BLINK_LAST = BLINK_W'(BLINK_HALF - 1);

    localparam int ACT_HOLD = 64;   // stretch after the command drops
    localparam int ACT_W    = $clog2(ACT_HOLD + 1);
    localparam logic [ACT_W-1:0] ACT_LOAD = ACT_W'(ACT_HOLD);

endpackage
